/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cam_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_cam_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cam_top;

    import cam_pkg::*;

    localparam logic [WB_WIDTH-1:0] DATA_ADR = 32'h80;
    localparam int BUS_TIMEOUT   = 16;
    localparam int RESET_TIMEOUT = 64;
    localparam int RETRY_LIMIT   = 64;
    localparam int POLL_LIMIT    = 500;
    localparam int PCLK_HALF     = 4;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_WIDTH-1:0]   wb_adr;
    logic [WB_WIDTH-1:0]   wb_dat_w;
    logic [WB_WIDTH/8-1:0] wb_sel;
    logic [WB_WIDTH-1:0]   wb_dat_r;
    logic                  wb_ack;
    logic                  wb_rty;
    logic                  pclk;
    logic                  vsync;
    logic                  href;
    logic [D_WIDTH-1:0]    cam_d;
    logic                  sioc;
    logic                  siod;
    logic                  siod_oe;
    logic                  irq_new_frame;
    logic                  config_finished;
    logic [1:0]            first_word;

    // Bytes sent by the camera model, in order
    logic [7:0]            sent [$];

    // SCCB monitor state
    logic                  sioc_q;
    logic                  siod_q;
    logic                  mon_armed;
    int                    mon_cnt;
    int                    mon_stops;
    logic                  mon_siod [0:31];
    logic                  mon_oe [0:31];
    int                    irq_count;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cam_top i_dut (
        .clk               (clk),
        .rst_i             (rst),
        .wb_cyc_i          (wb_cyc),
        .wb_stb_i          (wb_stb),
        .wb_we_i           (wb_we),
        .wb_adr_i          (wb_adr),
        .wb_dat_i          (wb_dat_w),
        .wb_sel_i          (wb_sel),
        .wb_dat_o          (wb_dat_r),
        .wb_ack_o          (wb_ack),
        .wb_rty_o          (wb_rty),
        .pclk_i            (pclk),
        .vsync_i           (vsync),
        .href_i            (href),
        .d_i               (cam_d),
        .sioc_o            (sioc),
        .siod_o            (siod),
        .siod_oe_o         (siod_oe),
        .irq_new_frame_o   (irq_new_frame),
        .config_finished_o (config_finished),
        .out_first_word_o  (first_word)
    );

    //////////////////////////////////////////////////////////////////////
    // Monitors, sampled on the falling edge
    //////////////////////////////////////////////////////////////////////

    // Start is SIOD falling with SIOC high, stop is SIOD rising with SIOC high
    always @(negedge clk) begin
        if (rst) begin
            sioc_q    <= 1'b1;
            siod_q    <= 1'b1;
            mon_armed <= 1'b0;
            mon_cnt   <= 0;
            mon_stops <= 0;
        end else begin
            sioc_q <= sioc;
            siod_q <= siod;
            if (sioc && sioc_q && siod_q && !siod) begin
                mon_armed <= 1'b1;
                mon_cnt   <= 0;
            end else if (mon_armed && sioc && sioc_q && !siod_q && siod) begin
                mon_armed <= 1'b0;
                mon_stops <= mon_stops + 1;
            end else if (mon_armed && sioc && !sioc_q && mon_cnt < 32) begin
                // One sample per SIOC rising edge
                mon_siod[mon_cnt] <= siod;
                mon_oe[mon_cnt]   <= siod_oe;
                mon_cnt           <= mon_cnt + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            irq_count <= 0;
        end else if (irq_new_frame) begin
            irq_count <= irq_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [WB_WIDTH-1:0] exp,
                              input logic [WB_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%02h actual 0x%02h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus and camera drivers
    //////////////////////////////////////////////////////////////////////

    // Step to 1 ns after the next rising edge
    task automatic advance(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [WB_WIDTH-1:0] adr,
                             input logic [WB_WIDTH-1:0] dat,
                             output logic [WB_WIDTH-1:0] rdat, output logic rty);
        int cycles;
        advance(1);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = '1;
        cycles   = 0;
        @(negedge clk);
        while (!wb_ack && !wb_rty) begin
            cycles++;
            if (cycles > BUS_TIMEOUT) begin
                abort_run("Wishbone slave gave neither ack nor rty in time");
            end
            @(negedge clk);
        end
        if (wb_ack && wb_rty) begin
            abort_run("Wishbone slave raised ack and rty together");
        end
        rdat = wb_dat_r;
        rty  = wb_rty;
        // Strobe drops for at least one cycle
        advance(1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_WIDTH-1:0] adr, input logic [WB_WIDTH-1:0] dat,
                            output logic rty);
        logic [WB_WIDTH-1:0] unused;
        bus_cycle(1'b1, adr, dat, unused, rty);
    endtask

    task automatic wb_read(input logic [WB_WIDTH-1:0] adr, output logic [WB_WIDTH-1:0] dat,
                           output logic rty);
        bus_cycle(1'b0, adr, '0, dat, rty);
    endtask

    // Retry until the FIFO has a word
    task automatic read_pixel_word(output logic [WB_WIDTH-1:0] dat);
        logic rty;
        int   tries;
        tries = 0;
        wb_read(DATA_ADR, dat, rty);
        while (rty) begin
            tries++;
            if (tries > RETRY_LIMIT) begin
                abort_run("Pixel FIFO stayed empty while a word was expected");
            end
            wb_read(DATA_ADR, dat, rty);
        end
    endtask

    task automatic wait_sccb_idle();
        logic [WB_WIDTH-1:0] status;
        logic                rty;
        int                  polls;
        polls = 0;
        wb_read(WB_WIDTH'(REG_STATUS), status, rty);
        while (status[0]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_run("SCCB serializer never left the busy state");
            end
            wb_read(WB_WIDTH'(REG_STATUS), status, rty);
        end
    endtask

    // pclk low with new data, then high
    task automatic cam_pclk_period(input logic line_on, input logic [D_WIDTH-1:0] data);
        pclk  = 1'b0;
        href  = line_on;
        cam_d = data;
        advance(PCLK_HALF);
        pclk  = 1'b1;
        advance(PCLK_HALF);
    endtask

    task automatic send_frame(input int lines, input int bytes_per_line);
        logic [31:0] rnd;
        vsync = 1'b1;
        repeat (2) cam_pclk_period(1'b0, '0);
        vsync = 1'b0;
        cam_pclk_period(1'b0, '0);
        for (int l = 0; l < lines; l++) begin
            for (int b = 0; b < bytes_per_line; b++) begin
                rnd = $urandom();
                sent.push_back(rnd[7:0]);
                cam_pclk_period(1'b1, rnd[7:0]);
            end
            // Blanking between lines
            repeat (2) cam_pclk_period(1'b0, '0);
        end
    endtask

    // First byte in the lowest lane
    function automatic logic [WB_WIDTH-1:0] pack_bytes(input int first);
        logic [WB_WIDTH-1:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = sent[first + k];
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        logic [WB_WIDTH-1:0] dat;
        logic                rty;
        int                  cycles;
        cycles = 0;
        // First edge, reset is surely asserted by now
        advance(1);
        while (rst) begin
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("Reset was never released");
            end
            advance(1);
        end
        check_bit("reset irq", 1'b0, irq_new_frame);
        check_bit("reset config_finished", 1'b0, config_finished);
        check_bit("reset ack", 1'b0, wb_ack);
        check_bit("reset rty", 1'b0, wb_rty);
        check_bit("reset siod_oe", 1'b0, siod_oe);
        check_bit("reset sioc", 1'b1, sioc);
        check_bit("reset siod", 1'b1, siod);
        check_flags("reset flags", 2'b00, first_word);
        // Nothing captured yet
        wb_read(DATA_ADR, dat, rty);
        check_bit("empty read rty", 1'b1, rty);
    endtask

    task automatic test_pixel_packing();
        logic [WB_WIDTH-1:0] dat;
        int                  irq_before;
        irq_before = irq_count;
        sent.delete();
        send_frame(2, 8);
        for (int i = 0; i < 4; i++) begin
            read_pixel_word(dat);
            check_word($sformatf("pixel word %0d", i), pack_bytes(4 * i), dat);
            // Word 0 opens frame and line, word 2 opens the second line
            check_flags($sformatf("pixel flags %0d", i), {(i % 2 == 0), (i == 0)},
                        first_word);
        end
        check_bit("single frame irq", 1'b1, (irq_count == irq_before + 1));
    endtask

    task automatic test_sccb_write();
        logic       rty;
        logic [7:0] got;
        int         stops_before;
        stops_before = mon_stops;
        wb_write(WB_WIDTH'(REG_SCCB), 32'h1280, rty);
        check_bit("sccb write rty", 1'b0, rty);
        wb_write(WB_WIDTH'(REG_SCCB), 32'h3456, rty);
        check_bit("sccb busy write rty", 1'b1, rty);
        wait_sccb_idle();
        check_bit("sccb one stop", 1'b1, (mon_stops == stops_before + 1));
        check_bit("sccb bit count", 1'b1, (mon_cnt >= 27));
        // Each phase is 8 bits MSB first plus a released bit
        for (int k = 0; k < 8; k++) begin
            got[7-k] = mon_siod[k];
        end
        check_byte("sccb id", SCCB_ID, got);
        for (int k = 0; k < 8; k++) begin
            got[7-k] = mon_siod[9 + k];
        end
        check_byte("sccb sub-address", 8'h12, got);
        for (int k = 0; k < 8; k++) begin
            got[7-k] = mon_siod[18 + k];
        end
        check_byte("sccb data", 8'h80, got);
        check_bit("sccb dc 1 oe", 1'b0, mon_oe[8]);
        check_bit("sccb dc 2 oe", 1'b0, mon_oe[17]);
        check_bit("sccb dc 3 oe", 1'b0, mon_oe[26]);
    endtask

    task automatic test_config_flag();
        logic [WB_WIDTH-1:0] status;
        logic                rty;
        int                  cycles;
        wb_write(WB_WIDTH'(REG_CONFIG), 32'h1, rty);
        check_bit("config set rty", 1'b0, rty);
        cycles = 0;
        while (!config_finished) begin
            cycles++;
            if (cycles > POLL_LIMIT) begin
                abort_run("config_finished never went high");
            end
            advance(1);
        end
        wb_read(WB_WIDTH'(REG_STATUS), status, rty);
        check_bit("status config bit set", 1'b1, status[1]);
        check_bit("status busy bit", 1'b0, status[0]);
        wb_write(WB_WIDTH'(REG_CONFIG), 32'h0, rty);
        check_bit("config_finished cleared", 1'b0, config_finished);
        wb_read(WB_WIDTH'(REG_STATUS), status, rty);
        check_bit("status config bit clear", 1'b0, status[1]);
    endtask

    task automatic test_overflow();
        logic [WB_WIDTH-1:0] dat;
        logic                rty;
        sent.delete();
        // 24 words, nothing read meanwhile
        send_frame(3, 32);
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            read_pixel_word(dat);
            check_word($sformatf("overflow word %0d", i), pack_bytes(4 * i), dat);
        end
        wb_read(DATA_ADR, dat, rty);
        check_bit("overflow drained rty", 1'b1, rty);
    endtask

    initial begin
        int unsigned seed_ret;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        pclk     = 1'b0;
        vsync    = 1'b0;
        href     = 1'b0;
        cam_d    = '0;
        seed_ret = $urandom(49);
        test_reset_state();
        test_pixel_packing();
        test_sccb_write();
        test_config_flag();
        test_overflow();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held for 16 rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/cam_pixel_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_pixel_packer (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        pclk_i,
    input  logic                        vsync_i,
    input  logic                        href_i,
    input  logic [cam_pkg::D_WIDTH-1:0] d_i,
    output logic                        irq_new_frame_o,
    cam_word_if.producer                out_o
);

    import cam_pkg::*;

    // Two sync stages and one edge stage per pin
    logic [2:0]          pclk_sr;
    logic [2:0]          vsync_sr;
    logic [2:0]          href_sr;
    // Data delayed to line up with the pclk edge
    logic [D_WIDTH-1:0]  d_s1;
    logic [D_WIDTH-1:0]  d_s2;
    logic                pclk_rise;
    logic                vsync_rise;
    logic                href_rise;
    logic                href_lvl;

    logic [1:0]          byte_cnt;
    logic [WB_WIDTH-1:0] shift_q;
    logic [WB_WIDTH-1:0] shift_nxt;
    logic                sof_pend;
    logic                sol_pend;
    logic                word_done;
    logic                load;

    ////////////////////////////////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pclk_sr  <= '0;
            vsync_sr <= '0;
            href_sr  <= '0;
        end else begin
            pclk_sr  <= {pclk_sr[1:0], pclk_i};
            vsync_sr <= {vsync_sr[1:0], vsync_i};
            href_sr  <= {href_sr[1:0], href_i};
        end
    end

    always_ff @(posedge clk) begin
        d_s1 <= d_i;
        d_s2 <= d_s1;
    end

    assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
    assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];
    assign href_rise  = href_sr[1] & ~href_sr[2];
    assign href_lvl   = href_sr[1];

    // One-cycle frame interrupt
    always_ff @(posedge clk) begin
        if (rst_i) begin
            irq_new_frame_o <= 1'b0;
        end else begin
            irq_new_frame_o <= vsync_rise;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Byte packing
    ////////////////////////////////////////////////////////////////////

    // First byte ends up in the low lane
    assign shift_nxt = {d_s2, shift_q[WB_WIDTH-1:D_WIDTH]};
    assign word_done = pclk_rise && href_lvl && (byte_cnt == 2'd3);
    // Drop the new word if the held one still waits
    assign load      = word_done && (!out_o.valid || out_o.ready);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            byte_cnt <= '0;
            sof_pend <= 1'b0;
            sol_pend <= 1'b0;
        end else begin
            if (vsync_rise) begin
                sof_pend <= 1'b1;
                byte_cnt <= '0;
            end
            if (href_rise) begin
                sol_pend <= 1'b1;
                byte_cnt <= '0;
            end
            if (pclk_rise && href_lvl) begin
                byte_cnt <= byte_cnt + 2'd1;
                // Markers belong to the word just finished
                if (byte_cnt == 2'd3) begin
                    sof_pend <= 1'b0;
                    sol_pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pclk_rise && href_lvl) begin
            shift_q <= shift_nxt;
        end
    end

    // One-word output stage
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o.valid <= 1'b0;
        end else if (load) begin
            out_o.valid <= 1'b1;
        end else if (out_o.ready) begin
            out_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_o.word <= '{pixel: shift_nxt, sof: sof_pend, sol: sol_pend};
        end
    end

    // Held word must not change until the FIFO takes it
    a_word_hold : assert property (@(posedge clk) disable iff (rst_i)
        out_o.valid && !out_o.ready |=> out_o.valid && $stable(out_o.word));

endmodule

`default_nettype wire

/* logic/cam_pkg.sv */
`default_nettype none

package cam_pkg;

    // Bus and camera widths
    localparam int WB_WIDTH = 32;
    localparam int D_WIDTH  = 8;

    // Word buffer size and derived pointer/count widths
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    // Quarter-bit length in clk cycles, kept short for simulation
    localparam int SCCB_QUARTER = 4;
    localparam int SCCB_QCW     = $clog2(SCCB_QUARTER + 1);

    // Camera write ID
    localparam logic [7:0] SCCB_ID = 8'h42;

    // Control register map
    localparam logic [7:0] REG_SCCB   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_CONFIG = 8'h08;

    // Packed pixel word plus frame and line markers
    typedef struct packed {
        logic [WB_WIDTH-1:0] pixel;
        logic                sof;
        logic                sol;
    } cam_word_t;

endpackage

`default_nettype wire

/* logic/cam_sccb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_sccb_ctrl (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [cam_pkg::WB_WIDTH-1:0] wb_adr_i,
    input  logic [cam_pkg::WB_WIDTH-1:0] wb_dat_i,
    output logic [cam_pkg::WB_WIDTH-1:0] wb_dat_o,
    output logic                         wb_ack_o,
    output logic                         wb_rty_o,
    output logic                         sioc_o,
    output logic                         siod_o,
    output logic                         siod_oe_o,
    output logic                         config_finished_o
);

    import cam_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_START, S_BITS, S_STOP} sccb_state_t;

    sccb_state_t         state;
    logic [SCCB_QCW-1:0] q_cnt;
    logic [1:0]          phase;
    logic [4:0]          bit_cnt;
    // ID, dc, sub-address, dc, data, dc
    logic [26:0]         shift_q;
    logic                tick;
    logic                bit_end;
    logic                busy;
    logic                dc_bit;
    logic                req;
    logic                sccb_wr;
    logic                cfg_flag;

    ////////////////////////////////////////////////////////////////////
    // Register access
    ////////////////////////////////////////////////////////////////////

    assign req     = wb_stb_i && !wb_ack_o && !wb_rty_o;
    assign busy    = (state != S_IDLE);
    assign sccb_wr = req && wb_we_i && (wb_adr_i[7:0] == REG_SCCB) && !busy;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            wb_rty_o <= 1'b0;
            cfg_flag <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            wb_rty_o <= 1'b0;
            if (req) begin
                // Serializer busy, write is refused
                if (wb_we_i && (wb_adr_i[7:0] == REG_SCCB) && busy) begin
                    wb_rty_o <= 1'b1;
                end else begin
                    wb_ack_o <= 1'b1;
                end
                if (wb_we_i && (wb_adr_i[7:0] == REG_CONFIG)) begin
                    cfg_flag <= wb_dat_i[0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            if (wb_adr_i[7:0] == REG_STATUS) begin
                wb_dat_o <= {{(WB_WIDTH-2){1'b0}}, cfg_flag, busy};
            end else begin
                wb_dat_o <= '0;
            end
        end
    end

    assign config_finished_o = cfg_flag && !busy;

    ////////////////////////////////////////////////////////////////////
    // SCCB write serializer
    ////////////////////////////////////////////////////////////////////

    assign tick    = (q_cnt == SCCB_QCW'(SCCB_QUARTER - 1));
    assign bit_end = tick && (phase == 2'd3);
    // Ninth bit of each phase is released
    assign dc_bit  = (bit_cnt == 5'd8) || (bit_cnt == 5'd17) || (bit_cnt == 5'd26);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= S_IDLE;
            q_cnt   <= '0;
            phase   <= '0;
            bit_cnt <= '0;
        end else if (state == S_IDLE) begin
            q_cnt   <= '0;
            phase   <= '0;
            bit_cnt <= '0;
            if (sccb_wr) begin
                state <= S_START;
            end
        end else begin
            q_cnt <= tick ? '0 : q_cnt + 1'b1;
            if (tick) begin
                phase <= phase + 2'd1;
            end
            if (bit_end) begin
                case (state)
                    S_START: state <= S_BITS;
                    S_BITS: begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd26) begin
                            state <= S_STOP;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // MSB goes out first
    always_ff @(posedge clk) begin
        if (sccb_wr) begin
            shift_q <= {SCCB_ID, 1'b1, wb_dat_i[15:8], 1'b1, wb_dat_i[7:0], 1'b1};
        end else if (state == S_BITS && bit_end) begin
            shift_q <= {shift_q[25:0], 1'b0};
        end
    end

    // Line levels per state and quarter
    always_comb begin
        sioc_o    = 1'b1;
        siod_o    = 1'b1;
        siod_oe_o = 1'b1;
        case (state)
            S_IDLE: begin
                siod_oe_o = 1'b0;
            end
            // SIOD falls in the second half with SIOC high
            S_START: begin
                siod_o = !phase[1];
            end
            // Low for quarters 0 and 1, high for 2 and 3
            S_BITS: begin
                sioc_o    = phase[1];
                siod_o    = shift_q[26];
                siod_oe_o = !dc_bit;
            end
            // SIOD rises in the last quarter with SIOC high
            S_STOP: begin
                sioc_o = phase[1];
                siod_o = (phase == 2'd3);
            end
            default: begin
                siod_oe_o = 1'b0;
            end
        endcase
    end

    // Data only moves while the clock line is low
    a_siod_stable : assert property (@(posedge clk) disable iff (rst_i)
        state == S_BITS && sioc_o && $past(sioc_o) |-> $stable(siod_o));

endmodule

`default_nettype wire

/* logic/cam_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_top (
    input  logic                           clk,
    input  logic                           rst_i,
    // Wishbone slave
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [cam_pkg::WB_WIDTH-1:0]   wb_adr_i,
    input  logic [cam_pkg::WB_WIDTH-1:0]   wb_dat_i,
    input  logic [cam_pkg::WB_WIDTH/8-1:0] wb_sel_i,
    output logic [cam_pkg::WB_WIDTH-1:0]   wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           wb_rty_o,
    // Camera pins
    input  logic                           pclk_i,
    input  logic                           vsync_i,
    input  logic                           href_i,
    input  logic [cam_pkg::D_WIDTH-1:0]    d_i,
    // SCCB with split data direction
    output logic                           sioc_o,
    output logic                           siod_o,
    output logic                           siod_oe_o,
    // Status
    output logic                           irq_new_frame_o,
    output logic                           config_finished_o,
    output logic [1:0]                     out_first_word_o
);

    import cam_pkg::*;

    logic                bus_stb;
    logic                data_stb;
    logic                ctrl_stb;
    logic                data_ack;
    logic                ctrl_ack;
    logic                data_rty;
    logic                ctrl_rty;
    logic [WB_WIDTH-1:0] data_dat;
    logic [WB_WIDTH-1:0] ctrl_dat;
    logic [WB_WIDTH-1:0] sel_mask;
    logic [WB_WIDTH-1:0] wr_dat;

    cam_word_if pack_if ();
    cam_word_if read_if ();

    ////////////////////////////////////////////////////////////////////
    // Address decode on bit 7
    ////////////////////////////////////////////////////////////////////

    // 0x00..0x7F control, 0x80..0xFF pixel data
    assign bus_stb  = wb_cyc_i && wb_stb_i;
    assign data_stb = wb_adr_i[7] ? bus_stb : 1'b0;
    assign ctrl_stb = wb_adr_i[7] ? 1'b0 : bus_stb;

    assign wb_dat_o = wb_adr_i[7] ? data_dat : ctrl_dat;
    assign wb_ack_o = wb_adr_i[7] ? data_ack : ctrl_ack;
    assign wb_rty_o = wb_adr_i[7] ? data_rty : ctrl_rty;

    // Unselected byte lanes write as zero
    always_comb begin
        for (int i = 0; i < WB_WIDTH / 8; i++) begin
            sel_mask[8*i +: 8] = {8{wb_sel_i[i]}};
        end
    end

    assign wr_dat = wb_dat_i & sel_mask;

    cam_sccb_ctrl u_sccb_ctrl (
        .clk               (clk),
        .rst_i             (rst_i),
        .wb_stb_i          (ctrl_stb),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wr_dat),
        .wb_dat_o          (ctrl_dat),
        .wb_ack_o          (ctrl_ack),
        .wb_rty_o          (ctrl_rty),
        .sioc_o            (sioc_o),
        .siod_o            (siod_o),
        .siod_oe_o         (siod_oe_o),
        .config_finished_o (config_finished_o)
    );

    // Pixel path: packer, FIFO, bus reader
    cam_pixel_packer u_packer (
        .clk             (clk),
        .rst_i           (rst_i),
        .pclk_i          (pclk_i),
        .vsync_i         (vsync_i),
        .href_i          (href_i),
        .d_i             (d_i),
        .irq_new_frame_o (irq_new_frame_o),
        .out_o           (pack_if.producer)
    );

    cam_word_fifo u_fifo (
        .clk   (clk),
        .rst_i (rst_i),
        .in_i  (pack_if.consumer),
        .out_o (read_if.producer)
    );

    cam_wb_reader u_reader (
        .clk              (clk),
        .rst_i            (rst_i),
        .wb_stb_i         (data_stb),
        .wb_dat_o         (data_dat),
        .wb_ack_o         (data_ack),
        .wb_rty_o         (data_rty),
        .out_first_word_o (out_first_word_o),
        .in_i             (read_if.consumer)
    );

endmodule

`default_nettype wire

/* logic/cam_wb_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_wb_reader (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         wb_stb_i,
    output logic [cam_pkg::WB_WIDTH-1:0] wb_dat_o,
    output logic                         wb_ack_o,
    output logic                         wb_rty_o,
    output logic [1:0]                   out_first_word_o,
    cam_word_if.consumer                 in_i
);

    logic req;

    // Skip the cycle that is already being answered
    assign req = wb_stb_i && !wb_ack_o && !wb_rty_o;

    // Head word leaves the FIFO with the request
    assign in_i.ready = req;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o         <= 1'b0;
            wb_rty_o         <= 1'b0;
            out_first_word_o <= 2'b00;
        end else begin
            wb_ack_o <= req && in_i.valid;
            // Empty buffer asks the master to retry
            wb_rty_o <= req && !in_i.valid;
            if (req && in_i.valid) begin
                out_first_word_o <= {in_i.word.sol, in_i.word.sof};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && in_i.valid) begin
            wb_dat_o <= in_i.word.pixel;
        end
    end

    // Ack and retry are exclusive
    a_ack_rty_excl : assert property (@(posedge clk) disable iff (rst_i)
        !(wb_ack_o && wb_rty_o));

endmodule

`default_nettype wire

/* logic/cam_word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_word_fifo (
    input  logic         clk,
    input  logic         rst_i,
    cam_word_if.consumer in_i,
    cam_word_if.producer out_o
);

    import cam_pkg::*;

    cam_word_t          mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               push;
    logic               pop;

    // Not full / not empty
    assign in_i.ready  = (count != FIFO_CW'(FIFO_DEPTH));
    assign out_o.valid = (count != '0);
    assign out_o.word  = mem[rd_ptr];

    assign push = in_i.valid && in_i.ready;
    assign pop  = out_o.valid && out_o.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_i.word;
        end
    end

    // Depth is a power of two so the pointers wrap by themselves
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Count bounds
    a_no_overflow : assert property (@(posedge clk) disable iff (rst_i)
        count <= FIFO_CW'(FIFO_DEPTH));

    // An empty FIFO can only grow
    a_no_underflow : assert property (@(posedge clk) disable iff (rst_i)
        count == '0 |=> count <= FIFO_CW'(1));

endmodule

`default_nettype wire

/* logic/cam_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cam_word_if;

    import cam_pkg::*;

    // Valid/ready handshake
    logic      valid;
    logic      ready;
    cam_word_t word;

    modport producer (
        output valid,
        output word,
        input  ready
    );

    modport consumer (
        input  valid,
        input  word,
        output ready
    );

endinterface

`default_nettype wire

/* vlog.f */
logic/cam_pkg.sv
logic/cam_word_if.sv
logic/cam_pixel_packer.sv
logic/cam_word_fifo.sv
logic/cam_wb_reader.sv
logic/cam_sccb_ctrl.sv
logic/cam_top.sv
bench/tb_clk_gen.sv
bench/tb_cam_top.sv
